// File: rtl/game_pkg.sv
`default_nettype none

package game_pkg;

    // board widths
    typedef logic [6:0] pattern_t;
    typedef logic [1:0] level_t;
    typedef logic [2:0] ticks_t;

    typedef enum logic [2:0]
    {
        st_idle,
        st_show,
        st_recall,
        st_judge,
        st_won
    } game_state_t;

    // kept short for simulation
    localparam int     TICK_CYCLES      = 8;
    localparam ticks_t SHOW_TICKS       = 3'd3;
    localparam int     SCAN_CYCLES      = 4;
    localparam int     MISS_BEEP_CYCLES = 6;
    localparam int     WIN_BEEP_CYCLES  = 20;
    localparam level_t LAST_LEVEL       = 2'd3;

    // counter widths
    localparam int TICK_W = $clog2(TICK_CYCLES);
    localparam int SCAN_W = $clog2(SCAN_CYCLES);
    localparam int BEEP_W = $clog2(WIN_BEEP_CYCLES + 1);

    // x^8 + x^6 + x^5 + x^4 + 1, right-shifting form
    localparam logic [7:0] LFSR_SEED = 8'hA5;
    localparam logic [7:0] LFSR_TAPS = 8'hB8;

    // 4 + level bits are compared
    function automatic pattern_t level_mask(input level_t level);
        case (level)
            2'd1:    level_mask = 7'h1f;
            2'd2:    level_mask = 7'h3f;
            default: level_mask = 7'h7f;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: rtl/game_ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

interface game_ctrl_if;

    import game_pkg::*;

    // controller side
    level_t   level;
    pattern_t pattern;
    logic     showing;
    logic     won;
    logic     timer_start;
    logic     miss_pulse;
    logic     win_pulse;

    // timer side
    logic     timer_over;
    ticks_t   remaining;

    modport ctrl
    (
        output level,
        output pattern,
        output showing,
        output won,
        output timer_start,
        output miss_pulse,
        output win_pulse,
        input  timer_over
    );

    modport timer
    (
        input  timer_start,
        output timer_over,
        output remaining
    );

    modport display
    (
        input level,
        input pattern,
        input showing,
        input won,
        input remaining
    );

    modport sound
    (
        input miss_pulse,
        input win_pulse
    );

endinterface

`default_nettype wire

// File: rtl/input_conditioner.sv
`timescale 1ns/100ps
`default_nettype none

module input_conditioner
(
    input  wire                clk,
    input  wire                sw,
    input  wire game_pkg::pattern_t toggles,
    input  wire                go_btn,
    input  wire                start_btn,
    output game_pkg::pattern_t toggles_s,
    output logic               go_pulse,
    output logic               start_pulse
);

    import game_pkg::*;

    pattern_t   toggles_m;

    // bit 0 is go, bit 1 is start
    logic [1:0] btn_m;
    logic [1:0] btn_s;
    logic [1:0] btn_d;
    logic [1:0] press;

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            toggles_m <= '0;
            toggles_s <= '0;
            btn_m     <= '0;
            btn_s     <= '0;
            btn_d     <= '0;
            press     <= '0;
        end
        else
        begin
            // two-flop synchronizers
            toggles_m <= toggles;
            toggles_s <= toggles_m;
            btn_m     <= {start_btn, go_btn};
            btn_s     <= btn_m;
            // rising edge, registered so a press gives one pulse
            btn_d     <= btn_s;
            press     <= btn_s & ~btn_d;
        end
    end

    assign go_pulse    = press[0];
    assign start_pulse = press[1];

endmodule

`default_nettype wire

// File: rtl/pattern_lfsr.sv
`timescale 1ns/100ps
`default_nettype none

module pattern_lfsr
(
    input  wire                clk,
    input  wire                sw,
    output game_pkg::pattern_t rand_bits
);

    import game_pkg::*;

    logic [7:0] lfsr;

    // galois form, steps every cycle
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            lfsr <= LFSR_SEED;
        end
        else
        begin
            lfsr <= {1'b0, lfsr[7:1]} ^ (lfsr[0] ? LFSR_TAPS : 8'h00);
        end
    end

    // press timing decides which value gets captured
    assign rand_bits = lfsr[6:0];

endmodule

`default_nettype wire

// File: rtl/game_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module game_fsm
(
    input  wire                clk,
    input  wire                sw,
    input  wire game_pkg::pattern_t toggles_s,
    input  wire                go_pulse,
    input  wire                start_pulse,
    input  wire game_pkg::pattern_t rand_bits,
    game_ctrl_if.ctrl          ctrl
);

    import game_pkg::*;

    game_state_t state;
    logic        answer_ok;
    logic        draw;

    // only the low 4 + level bits count
    assign answer_ok = ((toggles_s ^ ctrl.pattern) & level_mask(ctrl.level)) == '0;

    // new pattern on go, or on a match that moves to the next round
    assign draw = go_pulse
                  || (state == st_judge && answer_ok && ctrl.level != LAST_LEVEL);

    always_ff @(posedge clk)
    begin
        if (draw)
        begin
            ctrl.pattern <= rand_bits;
        end
    end

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            state            <= st_idle;
            ctrl.level       <= level_t'(1);
            ctrl.showing     <= 1'b0;
            ctrl.won         <= 1'b0;
            ctrl.timer_start <= 1'b0;
            ctrl.miss_pulse  <= 1'b0;
            ctrl.win_pulse   <= 1'b0;
        end
        else
        begin
            ctrl.timer_start <= 1'b0;
            ctrl.miss_pulse  <= 1'b0;
            ctrl.win_pulse   <= 1'b0;

            if (go_pulse)
            begin
                // go restarts the game from any state
                state            <= st_show;
                ctrl.level       <= level_t'(1);
                ctrl.showing     <= 1'b1;
                ctrl.won         <= 1'b0;
                ctrl.timer_start <= 1'b1;
            end
            else
            begin
                case (state)
                    st_show:
                    begin
                        // a stale timer_over during a restart is ignored
                        if (ctrl.timer_over && !ctrl.timer_start)
                        begin
                            state        <= st_recall;
                            ctrl.showing <= 1'b0;
                        end
                    end
                    st_recall:
                    begin
                        if (start_pulse)
                        begin
                            state <= st_judge;
                        end
                    end
                    st_judge:
                    begin
                        if (!answer_ok)
                        begin
                            // same pattern again, same level
                            state            <= st_show;
                            ctrl.showing     <= 1'b1;
                            ctrl.timer_start <= 1'b1;
                            ctrl.miss_pulse  <= 1'b1;
                        end
                        else if (ctrl.level == LAST_LEVEL)
                        begin
                            state          <= st_won;
                            ctrl.won       <= 1'b1;
                            ctrl.win_pulse <= 1'b1;
                        end
                        else
                        begin
                            state            <= st_show;
                            ctrl.level       <= ctrl.level + 1'b1;
                            ctrl.showing     <= 1'b1;
                            ctrl.timer_start <= 1'b1;
                        end
                    end
                    default:
                    begin
                        // idle and won wait for go
                        state <= state;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/round_timer.sv
`timescale 1ns/100ps
`default_nettype none

module round_timer
(
    input  wire        clk,
    input  wire        sw,
    game_ctrl_if.timer tmr
);

    import game_pkg::*;

    logic [TICK_W-1:0] prescale;
    logic              running;

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            prescale       <= '0;
            running        <= 1'b0;
            tmr.remaining  <= '0;
            tmr.timer_over <= 1'b0;
        end
        else
        begin
            tmr.timer_over <= 1'b0;

            if (tmr.timer_start)
            begin
                // reload, also restarts a countdown in progress
                prescale      <= '0;
                running       <= 1'b1;
                tmr.remaining <= SHOW_TICKS;
            end
            else if (running)
            begin
                if (prescale == TICK_W'(TICK_CYCLES - 1))
                begin
                    prescale      <= '0;
                    tmr.remaining <= tmr.remaining - 1'b1;
                    // last tick, pulse once and stop
                    if (tmr.remaining == ticks_t'(1))
                    begin
                        running        <= 1'b0;
                        tmr.timer_over <= 1'b1;
                    end
                end
                else
                begin
                    prescale <= prescale + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/display_driver.sv
`timescale 1ns/100ps
`default_nettype none

module display_driver
(
    input  wire          clk,
    input  wire          sw,
    game_ctrl_if.display disp,
    output logic [15:0]  led,
    output logic [7:0]   seg,
    output logic [7:0]   dig
);

    import game_pkg::*;

    logic [SCAN_W-1:0] scan_cnt;
    logic              digit_sel;
    logic              active;
    ticks_t            digit_val;

    // active-low segments g..a
    function automatic logic [6:0] seg_decode(input ticks_t value);
        case (value)
            3'd0:    seg_decode = 7'b1000000;
            3'd1:    seg_decode = 7'b1111001;
            3'd2:    seg_decode = 7'b0100100;
            3'd3:    seg_decode = 7'b0110000;
            3'd4:    seg_decode = 7'b0011001;
            3'd5:    seg_decode = 7'b0010010;
            3'd6:    seg_decode = 7'b0000010;
            default: seg_decode = 7'b1111000;
        endcase
    endfunction

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            scan_cnt  <= '0;
            digit_sel <= 1'b0;
            active    <= 1'b0;
        end
        else
        begin
            // leaves idle on the first memorize phase
            if (disp.showing)
            begin
                active <= 1'b1;
            end
            if (scan_cnt == SCAN_W'(SCAN_CYCLES - 1))
            begin
                scan_cnt  <= '0;
                digit_sel <= ~digit_sel;
            end
            else
            begin
                scan_cnt <= scan_cnt + 1'b1;
            end
        end
    end

    // digit 0 level, digit 1 remaining ticks
    assign digit_val = digit_sel ? disp.remaining : ticks_t'(disp.level);

    always_comb
    begin
        if (disp.won)
            led = '1;
        else if (disp.showing)
            led = {9'd0, disp.pattern & level_mask(disp.level)};
        else
            led = '0;
    end

    always_comb
    begin
        if (!active)
        begin
            dig = 8'hff;
            seg = 8'hff;
        end
        else
        begin
            dig = digit_sel ? 8'hfd : 8'hfe;
            // decimal point stays off
            seg = {1'b1, seg_decode(digit_val)};
        end
    end

endmodule

`default_nettype wire

// File: rtl/buzzer.sv
`timescale 1ns/100ps
`default_nettype none

module buzzer
(
    input  wire        clk,
    input  wire        sw,
    game_ctrl_if.sound snd,
    output logic       beep
);

    import game_pkg::*;

    logic [BEEP_W-1:0] beep_cnt;

    // a new pulse reloads, even mid-beep
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            beep_cnt <= '0;
        end
        else if (snd.win_pulse)
        begin
            beep_cnt <= BEEP_W'(WIN_BEEP_CYCLES);
        end
        else if (snd.miss_pulse)
        begin
            beep_cnt <= BEEP_W'(MISS_BEEP_CYCLES);
        end
        else if (beep_cnt != '0)
        begin
            beep_cnt <= beep_cnt - 1'b1;
        end
    end

    // plain level, no tone
    assign beep = (beep_cnt != '0);

endmodule

`default_nettype wire

// File: rtl/memory_game_top.sv
`timescale 1ns/100ps
`default_nettype none

module memory_game_top
(
    input  wire                clk,
    input  wire                sw,
    input  wire                go_btn,
    input  wire                start_btn,
    input  wire game_pkg::pattern_t toggles,
    output wire [15:0]         led,
    output wire [7:0]          seg,
    output wire [7:0]          dig,
    output wire                beep
);

    import game_pkg::*;

    pattern_t toggles_s;
    pattern_t rand_bits;
    wire      go_pulse;
    wire      start_pulse;

    game_ctrl_if ctrl_bus ();

    input_conditioner i_input_conditioner
    (
        .clk         (clk),
        .sw          (sw),
        .toggles     (toggles),
        .go_btn      (go_btn),
        .start_btn   (start_btn),
        .toggles_s   (toggles_s),
        .go_pulse    (go_pulse),
        .start_pulse (start_pulse)
    );

    pattern_lfsr i_pattern_lfsr
    (
        .clk       (clk),
        .sw        (sw),
        .rand_bits (rand_bits)
    );

    game_fsm i_game_fsm
    (
        .clk         (clk),
        .sw          (sw),
        .toggles_s   (toggles_s),
        .go_pulse    (go_pulse),
        .start_pulse (start_pulse),
        .rand_bits   (rand_bits),
        .ctrl        (ctrl_bus.ctrl)
    );

    round_timer i_round_timer
    (
        .clk (clk),
        .sw  (sw),
        .tmr (ctrl_bus.timer)
    );

    display_driver i_display_driver
    (
        .clk  (clk),
        .sw   (sw),
        .disp (ctrl_bus.display),
        .led  (led),
        .seg  (seg),
        .dig  (dig)
    );

    buzzer i_buzzer
    (
        .clk  (clk),
        .sw   (sw),
        .snd  (ctrl_bus.sound),
        .beep (beep)
    );

endmodule

`default_nettype wire

// File: verif/game_checker.sv
`timescale 1ns/100ps
`default_nettype none

module game_checker
(
    input  wire                   clk,
    input  wire                   sw,
    input  wire                   go_btn,
    input  wire [15:0]            led,
    input  wire [7:0]             seg,
    input  wire [7:0]             dig,
    input  wire                   beep,
    input  wire game_pkg::level_t exp_level,
    input  wire [15:0]            exp_pattern,
    input  wire                   check_pattern,
    input  wire                   sample,
    input  wire                   closing,
    input  int                    exp_beep,
    input  int                    exp_beeps,
    output int                    errors,
    output int                    checks
);

    import game_pkg::*;

    logic go_seen;
    logic level_pending;
    logic beep_d;
    int   beep_len;
    int   beep_count;
    int   last_rem;
    int   digit_value;
    int   show_len;

    // active-low segments g..a
    function automatic int decode_digit(input logic [6:0] s);
        case (s)
            7'b1000000: decode_digit = 0;
            7'b1111001: decode_digit = 1;
            7'b0100100: decode_digit = 2;
            7'b0110000: decode_digit = 3;
            7'b0011001: decode_digit = 4;
            7'b0010010: decode_digit = 5;
            7'b0000010: decode_digit = 6;
            7'b1111000: decode_digit = 7;
            default:    decode_digit = -1;
        endcase
    endfunction

    // round n compares 4 + n bits
    function automatic logic [15:0] width_mask(input level_t lv);
        width_mask = (16'd1 << (4 + int'(lv))) - 16'd1;
    endfunction

    task automatic report_error(input string msg);
        errors = errors + 1;
        $display("FAILED %0t: %s", $time, msg);
    endtask

    initial
    begin
        go_seen       = 1'b0;
        level_pending = 1'b0;
        beep_d        = 1'b0;
        beep_len      = 0;
        beep_count    = 0;
        last_rem      = int'(SHOW_TICKS);
        show_len      = 0;
        errors        = 0;
        checks        = 0;
    end

    always @(posedge clk)
    begin
        if (!sw)
        begin
            if (go_btn)
                go_seen = 1'b1;
            if (!go_seen && (led != 16'd0 || beep || dig != 8'hff || seg != 8'hff))
                report_error("outputs changed before go was pressed");

            // masked pattern while memorizing
            if (led != 16'hffff && (led & ~width_mask(exp_level)) != 16'd0)
                report_error($sformatf("led %h wider than level %0d", led, exp_level));

            // memorize phase length within the input delay
            if (led != 16'd0 && led != 16'hffff)
            begin
                show_len = show_len + 1;
            end
            else if (show_len != 0)
            begin
                checks = checks + 1;
                if (show_len < int'(SHOW_TICKS) * TICK_CYCLES - 3
                    || show_len > int'(SHOW_TICKS) * TICK_CYCLES + 3)
                    report_error($sformatf("memorize phase lasted %0d cycles, expected %0d",
                                           show_len, int'(SHOW_TICKS) * TICK_CYCLES));
                show_len = 0;
            end

            if (dig == 8'hfe || dig == 8'hfd)
            begin
                digit_value = decode_digit(seg[6:0]);
                if (digit_value < 0 || !seg[7])
                begin
                    report_error($sformatf("seg %h is no digit", seg));
                end
                else if (dig == 8'hfe && level_pending)
                begin
                    checks        = checks + 1;
                    level_pending = 1'b0;
                    if (digit_value != int'(exp_level))
                        report_error($sformatf("level digit %0d, expected %0d",
                                               digit_value, exp_level));
                end
                else if (dig == 8'hfd)
                begin
                    if (digit_value > int'(SHOW_TICKS))
                        report_error($sformatf("tick digit %0d too large", digit_value));
                    else if (digit_value > last_rem && digit_value != int'(SHOW_TICKS))
                        report_error("countdown went up");
                    last_rem = digit_value;
                end
            end

            if (sample)
            begin
                level_pending = 1'b1;
                checks        = checks + 1;
                if (check_pattern && led != exp_pattern)
                    report_error($sformatf("pattern %h after miss, expected %h",
                                           led, exp_pattern));
            end

            // beep length per event
            if (beep)
            begin
                beep_len = beep_len + 1;
                if (!beep_d && exp_beep == 0)
                    report_error("beep without a miss or win");
            end
            else if (beep_d)
            begin
                beep_count = beep_count + 1;
                checks     = checks + 1;
                if (beep_len != exp_beep)
                    report_error($sformatf("beep lasted %0d cycles, expected %0d",
                                           beep_len, exp_beep));
                beep_len = 0;
            end
            beep_d = beep;

            if (closing)
            begin
                checks = checks + 1;
                if (beep_count != exp_beeps)
                    report_error($sformatf("%0d beeps, expected %0d", beep_count, exp_beeps));
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_memory_game.sv
`timescale 1ns/100ps
`default_nettype none

module tb_memory_game;

    import game_pkg::*;

    localparam int         ROWS       = 7;
    localparam int         WAIT_LIMIT = 400;
    localparam int         EV_SHOW    = 0;
    localparam int         EV_RECALL  = 1;
    localparam int         EV_WON     = 2;
    // digit 1 encodings for 3 and 0 ticks
    localparam logic [7:0] SEG_SHOW   = 8'hb0;
    localparam logic [7:0] SEG_ZERO   = 8'hc0;

    // per row restart, answer, level during the round and beep length
    // answer 1 is right, 0 is wrong, 2 gives no answer
    bit row_restart [ROWS] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
    int row_answer  [ROWS] = '{1, 0, 1, 1, 0, 1, 2};
    int row_level   [ROWS] = '{1, 2, 2, 3, 1, 1, 2};
    int row_beep    [ROWS] = '{0, 6, 0, 20, 6, 0, 0};

    logic        clk;
    logic        sw;
    logic        go_btn;
    logic        start_btn;
    pattern_t    toggles;
    wire  [15:0] led;
    wire  [7:0]  seg;
    wire  [7:0]  dig;
    wire         beep;

    level_t      exp_level;
    logic [15:0] exp_pattern;
    logic        check_pattern;
    logic        sample;
    logic        closing;
    int          exp_beep;
    int          exp_beeps;
    int          errors;
    int          checks;
    logic        timed_out;
    logic        prev_miss;
    logic [15:0] last_led;
    int          bit_idx;

    memory_game_top i_memory_game_top
    (
        .clk       (clk),
        .sw        (sw),
        .go_btn    (go_btn),
        .start_btn (start_btn),
        .toggles   (toggles),
        .led       (led),
        .seg       (seg),
        .dig       (dig),
        .beep      (beep)
    );

    game_checker i_game_checker
    (
        .clk           (clk),
        .sw            (sw),
        .go_btn        (go_btn),
        .led           (led),
        .seg           (seg),
        .dig           (dig),
        .beep          (beep),
        .exp_level     (exp_level),
        .exp_pattern   (exp_pattern),
        .check_pattern (check_pattern),
        .sample        (sample),
        .closing       (closing),
        .exp_beep      (exp_beep),
        .exp_beeps     (exp_beeps),
        .errors        (errors),
        .checks        (checks)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    task automatic cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    function automatic logic event_seen(input int which);
        case (which)
            EV_SHOW:   event_seen = (dig == 8'hfd && seg == SEG_SHOW);
            EV_RECALL: event_seen = (dig == 8'hfd && seg == SEG_ZERO && led == 16'd0);
            default:   event_seen = (led == 16'hffff);
        endcase
    endfunction

    task automatic wait_event(input int which, input string what);
        int n;
        n = 0;
        if (!timed_out)
        begin
            while (!event_seen(which) && n < WAIT_LIMIT)
            begin
                @(posedge clk);
                n = n + 1;
            end
            if (n >= WAIT_LIMIT)
            begin
                timed_out = 1'b1;
                $display("timeout at %0t: %s never came", $time, what);
            end
        end
    endtask

    task automatic press_go();
        go_btn <= 1'b1;
        cycles(4);
        go_btn <= 1'b0;
        cycles(4);
    endtask

    task automatic press_start();
        start_btn <= 1'b1;
        cycles(4);
        start_btn <= 1'b0;
        cycles(4);
    endtask

    initial
    begin
        void'($urandom(30));
        sw            = 1'b1;
        go_btn        = 1'b0;
        start_btn     = 1'b0;
        toggles       = '0;
        exp_level     = level_t'(1);
        exp_pattern   = '0;
        check_pattern = 1'b0;
        sample        = 1'b0;
        closing       = 1'b0;
        exp_beep      = 0;
        exp_beeps     = 0;
        timed_out     = 1'b0;
        prev_miss     = 1'b0;
        last_led      = '0;
        cycles(8);
        sw <= 1'b0;
        // idle phase where nothing may move yet
        cycles(10);

        for (int r = 0; r < ROWS; r++)
        begin
            if (!timed_out)
            begin
                exp_level <= level_t'(row_level[r]);
                if (row_restart[r])
                begin
                    if (prev_miss)
                        wait_event(EV_RECALL, "the recall phase before the restart");
                    press_go();
                end
                wait_event(EV_SHOW, "the memorize phase");
            end
            if (!timed_out)
            begin
                check_pattern <= !row_restart[r] && prev_miss;
                exp_pattern   <= last_led;
                last_led       = led;
                sample        <= 1'b1;
                @(posedge clk);
                sample <= 1'b0;
                if (row_answer[r] == 2)
                begin
                    cycles(12);
                    closing <= 1'b1;
                    @(posedge clk);
                    closing <= 1'b0;
                end
                else
                begin
                    wait_event(EV_RECALL, "the end of the memorize phase");
                    if (row_answer[r] == 1)
                    begin
                        toggles <= last_led[6:0];
                    end
                    else
                    begin
                        // one wrong bit inside the compared width
                        bit_idx = int'($urandom % (4 + row_level[r]));
                        toggles <= last_led[6:0] ^ (pattern_t'(1) << bit_idx);
                    end
                    cycles(4);
                    exp_beep <= row_beep[r];
                    if (row_beep[r] != 0)
                        exp_beeps <= exp_beeps + 1;
                    // a match below the last round raises the level
                    if (row_answer[r] == 1 && row_level[r] < int'(LAST_LEVEL))
                        exp_level <= level_t'(row_level[r] + 1);
                    press_start();
                    if (row_answer[r] == 1 && row_level[r] == int'(LAST_LEVEL))
                        wait_event(EV_WON, "the win state");
                    prev_miss = (row_answer[r] == 0);
                end
            end
        end

        cycles(2);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
rtl/game_pkg.sv
rtl/game_ctrl_if.sv
rtl/input_conditioner.sv
rtl/pattern_lfsr.sv
rtl/game_fsm.sv
rtl/round_timer.sv
rtl/display_driver.sv
rtl/buzzer.sv
rtl/memory_game_top.sv
verif/game_checker.sv
verif/tb_memory_game.sv

// File: Makefile
BIN  = obj_dir/Vtb_memory_game
SRCS = $(wildcard rtl/*.sv verif/*.sv)

.PHONY: all run clean

all: run

$(BIN): project.f $(SRCS)
	verilator --binary --timing --top-module tb_memory_game -f project.f -Mdir obj_dir

run: $(BIN)
	./$(BIN) | tee sim.log
	@! grep -q "TB FAILED" sim.log
	@grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
